// ==== source/cpu_types_pkg.sv ====
package cpu_types_pkg;

    localparam logic [15:0] reset_vector = 16'hfffc;  // Low byte of the reset vector

    // One-hot cycle state
    typedef struct packed {
        logic fetch;      // Opcode read, previous instruction writes back
        logic byte2;      // Operand low byte, or dummy read for implied
        logic byte3;      // Operand high byte
        logic zero_page;  // Read from $00nn
        logic absolute;   // Read from $nnnn
        logic modify1;    // RMW writes the old byte
        logic modify2;    // RMW writes the new byte
    } cycle_state_t;

    // Control word, one per enabled cycle
    typedef struct packed {
        struct packed {
            logic increment;  // PC + 1
            logic vector;     // PC from the two operand bytes
        } pc;
        struct packed {
            logic pc;         // Address = PC
            logic zero_page;  // Address = $00, data_reg
            logic absolute;   // Address = data_reg, low byte
            logic hold;       // Address of the last cycle
        } addr;
        struct packed {
            logic enable;     // Write cycle
            logic same;       // Write back the byte just read
            logic rmw;        // Write the RMW unit result
            logic store;      // Write A, X or Y
        } write;
        struct packed {
            logic data_in;    // DB = registered input
            logic rmw;
            logic alu;
            logic shift;      // Accumulator shift unit
            logic a;
            logic x;
            logic y;
            logic inc_x;
            logic inc_y;
            logic dec_x;
            logic dec_y;
        } db;
        struct packed {
            logic n_db7;      // N from DB bit 7
            logic v_clear;
            logic v_alu;
            logic d_ir5;      // Opcode bit 5 gives the new value
            logic i_ir5;
            logic z_dbz;      // Z when DB is zero
            logic c_ir5;
            logic c_alu;
            logic c_rmw;
            logic c_shift;
        } flag;
        struct packed {
            logic a;
            logic x;
            logic y;
        } load;               // Register strobes, DB is the source
    } control_t;

    typedef struct packed {
        logic [15:0] address;
        logic [7:0]  data;
        logic        write_enable;
    } bus_out_t;

endpackage

// ==== source/opcode_pkg.sv ====
package opcode_pkg;

    // Same opcode byte, read whole or by field
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] aaa;  // Operation
            logic [2:0] bbb;  // Addressing mode
            logic [1:0] cc;   // Group
        } f;
    } opcode_t;

    typedef enum logic [2:0] {
        alu_ora = 3'd0,
        alu_and = 3'd1,
        alu_eor = 3'd2,
        alu_adc = 3'd3,
        alu_lda = 3'd5,
        alu_sbc = 3'd7
    } alu_op_t;

    typedef enum logic [2:0] {
        shift_asl = 3'd0,
        shift_rol = 3'd1,
        shift_lsr = 3'd2,
        shift_ror = 3'd3,
        shift_dec = 3'd6,
        shift_inc = 3'd7
    } shift_op_t;

    // bbb codes
    localparam logic [2:0] mode_index_imm = 3'b000;  // LDX/LDY immediate
    localparam logic [2:0] mode_zero_page = 3'b001;
    localparam logic [2:0] mode_immediate = 3'b010;  // Implied/accumulator outside cc = 01
    localparam logic [2:0] mode_absolute  = 3'b011;

    localparam logic [7:0] op_tax     = 8'hAA;
    localparam logic [7:0] op_tay     = 8'hA8;
    localparam logic [7:0] op_txa     = 8'h8A;
    localparam logic [7:0] op_tya     = 8'h98;
    localparam logic [7:0] op_inx     = 8'hE8;
    localparam logic [7:0] op_iny     = 8'hC8;
    localparam logic [7:0] op_dex     = 8'hCA;
    localparam logic [7:0] op_dey     = 8'h88;
    localparam logic [7:0] op_clc     = 8'h18;
    localparam logic [7:0] op_sec     = 8'h38;
    localparam logic [7:0] op_cli     = 8'h58;
    localparam logic [7:0] op_sei     = 8'h78;
    localparam logic [7:0] op_cld     = 8'hD8;
    localparam logic [7:0] op_sed     = 8'hF8;
    localparam logic [7:0] op_clv     = 8'hB8;
    localparam logic [7:0] op_jmp_abs = 8'h4C;

endpackage

// ==== source/cpu_sequencer.sv ====
`timescale 1ns/1ns

module cpu_sequencer
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  logic [7:0]              data_reg,
    output cpu_types_pkg::control_t control,
    output opcode_pkg::opcode_t     opcode,
    output logic                    sync
);
    import cpu_types_pkg::*;
    import opcode_pkg::*;

    cycle_state_t state;
    cycle_state_t state_next;
    opcode_t      opcode_reg;
    logic         opcode_fresh;  // Opcode was read last cycle, still in data_reg

    logic implied;
    logic immediate;
    logic two_cycle;
    logic zero_page;
    logic absolute;
    logic load;
    logic store;
    logic arith;
    logic adc_sbc;
    logic acc_shift;
    logic modify;

    // In byte 2 the new opcode is only in the input register
    assign opcode.raw = opcode_fresh ? data_reg : opcode_reg.raw;
    assign sync       = state.fetch;

    // Group decode
    assign implied   = ~opcode.f.cc[0] & (opcode.f.bbb[1:0] == 2'b10);  // x10 with cc 00/10
    assign immediate = (opcode.f.cc[0] & (opcode.f.bbb == mode_immediate))
                     | (~opcode.f.cc[0] & (opcode.f.bbb == mode_index_imm) & opcode.f.aaa[2]);
    assign two_cycle = implied | immediate;
    assign zero_page = opcode.f.bbb == mode_zero_page;
    assign absolute  = opcode.f.bbb == mode_absolute;
    assign load      = (opcode.f.aaa == 3'b101) & ~implied;    // LDA LDX LDY
    assign store     = (opcode.f.aaa == 3'b100) & ~two_cycle;  // STA STX STY
    assign arith     = opcode.f.cc[0] & (opcode.f.aaa[2:1] != 2'b10);
    assign adc_sbc   = opcode.f.cc[0] & (opcode.f.aaa[1:0] == 2'b11);
    assign acc_shift = (opcode.f.cc == 2'b10) & (opcode.f.bbb == mode_immediate)
                     & ~opcode.f.aaa[2];
    assign modify    = opcode.f.cc[1] & (zero_page | absolute)
                     & (opcode.f.aaa[2:1] != 2'b10);          // Not STX/LDX

    always_comb
    begin
        control    = '0;
        state_next = '0;

        if (state.fetch)
        begin
            // Previous instruction writes back here
            state_next.byte2     = 1'b1;
            control.addr.pc      = 1'b1;
            control.pc.increment = 1'b1;
            control.db.data_in   = load;
            control.db.alu       = arith;
            control.db.shift     = acc_shift;
            control.db.a         = (opcode.raw == op_tax) | (opcode.raw == op_tay);
            control.db.x         = opcode.raw == op_txa;
            control.db.y         = opcode.raw == op_tya;
            control.db.inc_x     = opcode.raw == op_inx;
            control.db.inc_y     = opcode.raw == op_iny;
            control.db.dec_x     = opcode.raw == op_dex;
            control.db.dec_y     = opcode.raw == op_dey;
            control.load.a = (load & (opcode.f.cc == 2'b01)) | control.db.x | control.db.y
                           | arith | acc_shift;
            control.load.x = (load & (opcode.f.cc == 2'b10)) | (opcode.raw == op_tax)
                           | control.db.inc_x | control.db.dec_x;
            control.load.y = (load & (opcode.f.cc == 2'b00)) | (opcode.raw == op_tay)
                           | control.db.inc_y | control.db.dec_y;
            control.flag.n_db7   = control.load.a | control.load.x | control.load.y;
            control.flag.z_dbz   = control.flag.n_db7;
            control.flag.v_alu   = adc_sbc;
            control.flag.c_alu   = adc_sbc;
            control.flag.c_shift = acc_shift;
            control.flag.v_clear = opcode.raw == op_clv;
            control.flag.c_ir5   = (opcode.raw == op_clc) | (opcode.raw == op_sec);
            control.flag.i_ir5   = (opcode.raw == op_cli) | (opcode.raw == op_sei);
            control.flag.d_ir5   = (opcode.raw == op_cld) | (opcode.raw == op_sed);
        end

        if (state.byte2)
        begin
            control.addr.pc      = 1'b1;
            control.pc.increment = ~implied;  // Implied reads this byte again as opcode
            state_next.fetch     = two_cycle;
            state_next.zero_page = zero_page;
            state_next.byte3     = absolute;
        end

        if (state.byte3)
        begin
            control.addr.pc      = 1'b1;
            control.pc.increment = 1'b1;
            control.pc.vector    = opcode.raw == op_jmp_abs;  // Also the reset vector
            state_next.fetch     = control.pc.vector;
            state_next.absolute  = ~control.pc.vector;
        end

        if (state.zero_page | state.absolute)
        begin
            control.addr.zero_page = state.zero_page;
            control.addr.absolute  = state.absolute;
            state_next.modify1     = modify;
            state_next.fetch       = ~modify;
        end

        if (state.modify1)
        begin
            control.addr.hold    = 1'b1;
            control.write.enable = 1'b1;
            control.write.same   = 1'b1;  // Old byte out first
            state_next.modify2   = 1'b1;
        end

        if (state.modify2)
        begin
            control.addr.hold    = 1'b1;
            control.write.enable = 1'b1;
            control.write.rmw    = 1'b1;
            control.db.rmw       = 1'b1;
            control.flag.n_db7   = 1'b1;
            control.flag.z_dbz   = 1'b1;
            control.flag.c_rmw   = ~opcode.f.aaa[2];  // INC/DEC leave C alone
            state_next.fetch     = 1'b1;
        end

        // Store writes in the cycle that returns to fetch
        if (store & state_next.fetch)
        begin
            control.write.enable = 1'b1;
            control.write.store  = 1'b1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state          <= '{byte2: 1'b1, default: 1'b0};  // Pretend JMP, operand next
            opcode_reg.raw <= op_jmp_abs;
            opcode_fresh   <= 1'b0;
        end
        else if (enable)
        begin
            state        <= state_next;
            opcode_reg   <= opcode;
            opcode_fresh <= state.fetch;
        end
    end

endmodule

// ==== source/cpu_alu.sv ====
`timescale 1ns/1ns

module cpu_alu
(
    input  logic [7:0]           a,
    input  logic [7:0]           b,
    input  logic                 carry_in,
    input  opcode_pkg::alu_op_t  op,
    output logic [7:0]           result,
    output logic                 carry_out,
    output logic                 overflow
);
    import opcode_pkg::*;

    logic [7:0] addend;
    logic [8:0] sum;

    assign addend = (op == alu_sbc) ? ~b : b;  // SBC is A + ~B + C
    assign sum    = {1'b0, a} + {1'b0, addend} + 9'(carry_in);

    always_comb
    begin
        case (op)
            alu_ora:          result = a | b;
            alu_and:          result = a & b;
            alu_eor:          result = a ^ b;
            alu_lda:          result = b;        // Load passes B through
            alu_adc, alu_sbc: result = sum[7:0];
            default:          result = 8'h00;
        endcase
    end

    assign carry_out = sum[8];
    // Signs of both operands agree but the sum differs
    assign overflow  = (a[7] ^ sum[7]) & (addend[7] ^ sum[7]);

endmodule

// ==== source/cpu_shift.sv ====
`timescale 1ns/1ns

module cpu_shift
(
    input  logic [7:0]            value,
    input  logic                  carry_in,
    input  opcode_pkg::shift_op_t op,
    output logic [7:0]            result,
    output logic                  carry_out
);
    import opcode_pkg::*;

    always_comb
    begin
        result    = value;
        carry_out = 1'b0;
        case (op)
            shift_asl: {carry_out, result} = {value, 1'b0};
            shift_rol: {carry_out, result} = {value, carry_in};  // Through carry
            shift_lsr: {result, carry_out} = {1'b0, value};
            shift_ror: {result, carry_out} = {carry_in, value};
            shift_dec: result = value - 8'd1;
            shift_inc: result = value + 8'd1;
            default:   result = value;
        endcase
    end

endmodule

// ==== source/cpu_datapath.sv ====
`timescale 1ns/1ns

module cpu_datapath
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  cpu_types_pkg::control_t control,
    input  opcode_pkg::opcode_t     opcode,
    input  logic [7:0]              data_reg,
    input  logic [7:0]              alu_result,
    input  logic                    alu_carry,
    input  logic                    alu_overflow,
    input  logic [7:0]              acc_shift,
    input  logic                    acc_carry,
    input  logic [7:0]              rmw_result,
    input  logic                    rmw_carry,
    output logic [7:0]              a,
    output logic [7:0]              x,
    output logic [7:0]              y,
    output logic                    flag_c
);
    typedef struct packed {
        logic n;
        logic v;
        logic d;  // Stored only, no decimal adder
        logic i;
        logic z;
        logic c;
    } status_t;

    status_t    status;
    status_t    status_next;
    logic [7:0] db;  // Internal data bus

    always_comb
    begin
        if (control.db.data_in)    db = data_reg;
        else if (control.db.rmw)   db = rmw_result;
        else if (control.db.alu)   db = alu_result;
        else if (control.db.shift) db = acc_shift;
        else if (control.db.a)     db = a;
        else if (control.db.x)     db = x;
        else if (control.db.y)     db = y;
        else if (control.db.inc_x) db = x + 8'd1;
        else if (control.db.inc_y) db = y + 8'd1;
        else if (control.db.dec_x) db = x - 8'd1;
        else if (control.db.dec_y) db = y - 8'd1;
        else                       db = 8'h00;
    end

    always_comb
    begin
        status_next = status;
        if (control.flag.n_db7)   status_next.n = db[7];
        if (control.flag.z_dbz)   status_next.z = db == 8'h00;
        if (control.flag.v_clear) status_next.v = 1'b0;
        if (control.flag.v_alu)   status_next.v = alu_overflow;
        if (control.flag.d_ir5)   status_next.d = opcode.raw[5];  // CLD/SED
        if (control.flag.i_ir5)   status_next.i = opcode.raw[5];
        if (control.flag.c_ir5)   status_next.c = opcode.raw[5];  // CLC/SEC
        if (control.flag.c_alu)   status_next.c = alu_carry;
        if (control.flag.c_rmw)   status_next.c = rmw_carry;
        if (control.flag.c_shift) status_next.c = acc_carry;
    end

    assign flag_c = status.c;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            a      <= 8'h00;
            x      <= 8'h00;
            y      <= 8'h00;
            status <= '0;
        end
        else if (enable)
        begin
            if (control.load.a) a <= db;
            if (control.load.x) x <= db;
            if (control.load.y) y <= db;
            status <= status_next;
        end
    end

endmodule

// ==== source/cpu_address.sv ====
`timescale 1ns/1ns

module cpu_address
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  cpu_types_pkg::control_t control,
    input  logic [7:0]              data_in,
    input  logic [7:0]              a,
    input  logic [7:0]              x,
    input  logic [7:0]              y,
    input  opcode_pkg::opcode_t     opcode,
    input  logic [7:0]              rmw_result,
    output cpu_types_pkg::bus_out_t bus,
    output logic [7:0]              data_reg
);
    import cpu_types_pkg::*;

    logic [15:0] pc;
    logic [15:0] pc_next;
    logic [15:0] address_hold;  // Last bus address, for RMW writes
    logic [7:0]  address_low;   // Operand low byte while the high byte arrives
    logic [7:0]  store_data;

    // cc picks the register, as in STY/STA/STX
    always_comb
    begin
        case (opcode.f.cc)
            2'b00:   store_data = y;
            2'b10:   store_data = x;
            default: store_data = a;
        endcase
    end

    always_comb
    begin
        if (control.addr.pc)             bus.address = pc;
        else if (control.addr.zero_page) bus.address = {8'h00, data_reg};
        else if (control.addr.absolute)  bus.address = {data_reg, address_low};
        else if (control.addr.hold)      bus.address = address_hold;
        else                             bus.address = 16'h0000;

        if (control.write.same)       bus.data = data_reg;
        else if (control.write.rmw)   bus.data = rmw_result;
        else if (control.write.store) bus.data = store_data;
        else                          bus.data = 8'h00;

        bus.write_enable = control.write.enable;
    end

    // Vector high byte is on the bus this cycle, low byte came in before
    assign pc_next = control.pc.vector ? {data_in, data_reg}
                                       : pc + 16'(control.pc.increment);

    always_ff @(posedge clock)
    begin
        if (reset)
            pc <= reset_vector;
        else if (enable)
            pc <= pc_next;
    end

    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            address_hold <= bus.address;
            address_low  <= data_reg;
            data_reg     <= control.write.enable ? bus.data : data_in;  // Echo own writes
        end
    end

endmodule

// ==== source/cpu_core.sv ====
`timescale 1ns/1ns

module cpu_core
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    enable,
    input  logic [7:0]              data_in,
    output cpu_types_pkg::bus_out_t bus,
    output logic                    sync
);
    import cpu_types_pkg::*;
    import opcode_pkg::*;

    control_t   control;
    opcode_t    opcode;
    logic [7:0] data_reg;
    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    logic       flag_c;
    logic [7:0] alu_result;
    logic       alu_carry;
    logic       alu_overflow;
    logic [7:0] acc_result;    // Accumulator shift
    logic       acc_carry;
    logic [7:0] rmw_result;    // Memory shift or INC/DEC
    logic       rmw_carry;

    cpu_sequencer sequencer
    (
        .clock    (clock),
        .reset    (reset),
        .enable   (enable),
        .data_reg (data_reg),
        .control  (control),
        .opcode   (opcode),
        .sync     (sync)
    );

    cpu_alu alu
    (
        .a         (a),
        .b         (data_reg),
        .carry_in  (flag_c),
        .op        (alu_op_t'(opcode.f.aaa)),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    cpu_shift acc_shift
    (
        .value     (a),
        .carry_in  (flag_c),
        .op        (shift_op_t'(opcode.f.aaa)),
        .result    (acc_result),
        .carry_out (acc_carry)
    );

    cpu_shift rmw_shift
    (
        .value     (data_reg),  // Byte read back in modify 1
        .carry_in  (flag_c),
        .op        (shift_op_t'(opcode.f.aaa)),
        .result    (rmw_result),
        .carry_out (rmw_carry)
    );

    cpu_datapath datapath
    (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .control      (control),
        .opcode       (opcode),
        .data_reg     (data_reg),
        .alu_result   (alu_result),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow),
        .acc_shift    (acc_result),
        .acc_carry    (acc_carry),
        .rmw_result   (rmw_result),
        .rmw_carry    (rmw_carry),
        .a            (a),
        .x            (x),
        .y            (y),
        .flag_c       (flag_c)
    );

    cpu_address address
    (
        .clock      (clock),
        .reset      (reset),
        .enable     (enable),
        .control    (control),
        .data_in    (data_in),
        .a          (a),
        .x          (x),
        .y          (y),
        .opcode     (opcode),
        .rmw_result (rmw_result),
        .bus        (bus),
        .data_reg   (data_reg)
    );

endmodule

// ==== test/cpu_model.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Instruction-level reference of the kept 6502 subset, binary arithmetic only
logic [7:0]  ref_memory [0:65535];
logic [15:0] ref_pc;
logic [7:0]  ref_a;
logic [7:0]  ref_x;
logic [7:0]  ref_y;
logic        ref_c;          // Only flag that later results can show
logic [15:0] write_addr_queue[$];  // Writes the DUT still owes
logic [7:0]  write_data_queue[$];
logic [31:0] seed;

// Kept opcodes grouped by length: implied 0..18, immediate 19..26, zp 27..43, abs 44..60
localparam logic [7:0] opcode_table [61] = '{
    8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88, 8'h18, 8'h38,
    8'h58, 8'h78, 8'hD8, 8'hF8, 8'hB8, 8'h0A, 8'h2A, 8'h4A, 8'h6A,
    8'h09, 8'h29, 8'h49, 8'h69, 8'hE9, 8'hA9, 8'hA2, 8'hA0,
    8'h05, 8'h25, 8'h45, 8'h65, 8'hE5, 8'hA5, 8'h85, 8'hA6, 8'h86, 8'hA4,
    8'h84, 8'h06, 8'h26, 8'h46, 8'h66, 8'hC6, 8'hE6,
    8'h0D, 8'h2D, 8'h4D, 8'h6D, 8'hED, 8'hAD, 8'h8D, 8'hAE, 8'h8E, 8'hAC,
    8'h8C, 8'h0E, 8'h2E, 8'h4E, 8'h6E, 8'hCE, 8'hEE
};

function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

task automatic queue_write(input logic [15:0] address, input logic [7:0] data);
    ref_memory[address] = data;
    write_addr_queue.push_back(address);
    write_data_queue.push_back(data);
endtask

task automatic build_program();
    int          pick;
    logic [31:0] r;
    logic [15:0] at;
    for (int i = 0; i < 65536; i++)
        ref_memory[i] = 8'h00;
    at = 16'h0400;
    for (int n = 0; n < 300; n++)
    begin
        pick = int'(next_random() % 32'd61);
        r    = next_random();
        ref_memory[at] = opcode_table[pick];
        at = at + 16'd1;
        if (pick >= 19 && pick < 27)
        begin
            ref_memory[at] = r[7:0];  // Immediate byte
            at = at + 16'd1;
        end
        else if (pick >= 27 && pick < 44)
        begin
            ref_memory[at] = {2'b00, r[5:0]};  // $0000-$003F
            at = at + 16'd1;
        end
        else if (pick >= 44)
        begin
            ref_memory[at]         = r[7:0];  // $0200-$02FF
            ref_memory[at + 16'd1] = 8'h02;
            at = at + 16'd2;
        end
    end
    ref_memory[at]         = 8'h4C;  // Loop back to the start
    ref_memory[at + 16'd1] = 8'h00;
    ref_memory[at + 16'd2] = 8'h04;
    for (int i = 0; i < 64; i++)
    begin
        r = next_random();
        ref_memory[i]         = r[7:0];
        ref_memory[i + 'h200] = r[15:8];
        ref_memory[i + 'h240] = r[23:16];
        ref_memory[i + 'h280] = r[31:24];
        ref_memory[i + 'h2C0] = r[11:4];
    end
    ref_memory[16'hFFFC] = 8'h00;
    ref_memory[16'hFFFD] = 8'h04;
    ref_pc = 16'h0400;
    ref_a  = 8'h00;
    ref_x  = 8'h00;
    ref_y  = 8'h00;
    ref_c  = 1'b0;
endtask

// Runs the instruction at ref_pc and queues the writes it makes
task automatic execute_instruction();
    logic [7:0]  op;
    logic [7:0]  b1;
    logic [7:0]  v;
    logic [7:0]  r;
    logic [15:0] ea;
    logic [8:0]  sum;
    op = ref_memory[ref_pc];
    b1 = ref_memory[ref_pc + 16'd1];
    ea = {8'h00, b1};
    v  = b1;                                            // Immediate operand
    if (op[3:2] == 2'b01)                               // Zero page
        v = ref_memory[ea];
    else if (op[3:2] == 2'b11)
    begin
        ea = {ref_memory[ref_pc + 16'd2], b1};          // Absolute and JMP
        v  = ref_memory[ea];
    end
    if (op == 8'h4C)
        ref_pc = ea;
    else if (op[3:2] == 2'b11)
        ref_pc = ref_pc + 16'd3;
    else if (op[3:2] == 2'b01 || op == 8'hA2 || op == 8'hA0 || op[3:0] == 4'h9)
        ref_pc = ref_pc + 16'd2;
    else
        ref_pc = ref_pc + 16'd1;
    case (op)
        8'h09, 8'h05, 8'h0D: ref_a = ref_a | v;
        8'h29, 8'h25, 8'h2D: ref_a = ref_a & v;
        8'h49, 8'h45, 8'h4D: ref_a = ref_a ^ v;
        8'h69, 8'h65, 8'h6D, 8'hE9, 8'hE5, 8'hED:
        begin
            if (op[7]) v = ~v;                          // Subtract adds the complement
            sum   = {1'b0, ref_a} + {1'b0, v} + {8'd0, ref_c};
            ref_a = sum[7:0];
            ref_c = sum[8];
        end
        8'hA9, 8'hA5, 8'hAD: ref_a = v;
        8'hA2, 8'hA6, 8'hAE: ref_x = v;
        8'hA0, 8'hA4, 8'hAC: ref_y = v;
        8'h85, 8'h8D: queue_write(ea, ref_a);
        8'h86, 8'h8E: queue_write(ea, ref_x);
        8'h84, 8'h8C: queue_write(ea, ref_y);
        8'hAA: ref_x = ref_a;
        8'hA8: ref_y = ref_a;
        8'h8A: ref_a = ref_x;
        8'h98: ref_a = ref_y;
        8'hE8: ref_x = ref_x + 8'd1;
        8'hC8: ref_y = ref_y + 8'd1;
        8'hCA: ref_x = ref_x - 8'd1;
        8'h88: ref_y = ref_y - 8'd1;
        8'h18: ref_c = 1'b0;
        8'h38: ref_c = 1'b1;
        8'h0A: {ref_c, ref_a} = {ref_a, 1'b0};
        8'h2A: {ref_c, ref_a} = {ref_a, ref_c};
        8'h4A: {ref_a, ref_c} = {1'b0, ref_a};
        8'h6A: {ref_a, ref_c} = {ref_c, ref_a};
        8'h06, 8'h0E, 8'h26, 8'h2E, 8'h46, 8'h4E, 8'h66, 8'h6E,
        8'hC6, 8'hCE, 8'hE6, 8'hEE:
        begin
            case (op[7:5])
                3'd0:    {ref_c, r} = {v, 1'b0};
                3'd1:    {ref_c, r} = {v, ref_c};
                3'd2:    {r, ref_c} = {1'b0, v};
                3'd3:    {r, ref_c} = {ref_c, v};
                3'd6:    r = v - 8'd1;
                default: r = v + 8'd1;
            endcase
            queue_write(ea, v);                         // Old byte goes out first
            queue_write(ea, r);
        end
        default: ;                                      // I, D, V and JMP change nothing seen
    endcase
endtask

`endif

// ==== test/cpu_core_tb.sv ====
`timescale 1ns/1ns

module cpu_core_tb;
    import cpu_types_pkg::*;

    localparam int sync_target = 600;
    localparam int cycle_limit = sync_target * 6 * 2 + 50;  // Longest instruction with half stalled

    logic       clock;
    logic       reset;
    logic       enable;
    logic [7:0] data_in;
    bus_out_t   bus;
    logic       sync;

    logic [7:0]  memory [0:65535];
    int          check_errors;
    int          other_errors;
    int          sync_count;
    int          cycles;
    int          enabled_cycles;  // Since reset
    int          last_sync;       // Value of enabled_cycles at the previous sync
    int          owed_cycles;     // Length of the instruction begun there
    logic        prev_enable;
    logic [15:0] prev_address;
    logic        prev_write;

    `include "cpu_model.svh"

    cpu_core uut
    (
        .clock   (clock),
        .reset   (reset),
        .enable  (enable),
        .data_in (data_in),
        .bus     (bus),
        .sync    (sync)
    );

    assign data_in = memory[bus.address];  // Asynchronous read

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock)
    begin
        if (bus.write_enable && enable)
            memory[bus.address] <= bus.data;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (expected !== actual)
        begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    // Enabled cycles from one sync to the next
    function automatic int instruction_cycles(input logic [7:0] op);
        int n;
        case (op[3:2])
            2'b01:   n = 3;  // Zero page
            2'b11:   n = 4;  // Absolute
            default: n = 2;  // Implied, immediate and accumulator
        endcase
        case (op)
            8'h4C: n = 3;
            8'h06, 8'h0E, 8'h26, 8'h2E, 8'h46, 8'h4E, 8'h66, 8'h6E,
            8'hC6, 8'hCE, 8'hE6, 8'hEE: n = n + 2;  // Two write cycles of RMW
            default: ;
        endcase
        return n;
    endfunction

    // Sampled at the falling edge where outputs are stable
    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (!prev_enable)
            begin
                check_value("stalled bus.address", prev_address, bus.address);
                check_value("stalled bus.write_enable", 16'(prev_write), 16'(bus.write_enable));
            end
            if (enable)
            begin
                if (enabled_cycles < 2)  // Vector fetch
                begin
                    check_value("vector bus.address", 16'hFFFC + 16'(enabled_cycles),
                                bus.address);
                    check_value("vector bus.write_enable", 16'd0, 16'(bus.write_enable));
                end
                if (sync)
                begin
                    check_value("sync spacing", 16'(owed_cycles),
                                16'(enabled_cycles - last_sync));
                    check_value("sync bus.address", ref_pc, bus.address);
                    if (write_addr_queue.size() != 0)
                    begin
                        other_errors++;
                        $display("Missing write at %0t ns: %0d writes not seen before sync",
                                 $time, write_addr_queue.size());
                        write_addr_queue.delete();
                        write_data_queue.delete();
                    end
                    owed_cycles = instruction_cycles(ref_memory[ref_pc]);
                    last_sync   = enabled_cycles;
                    execute_instruction();
                    sync_count++;
                end
                if (bus.write_enable)
                begin
                    if (write_addr_queue.size() == 0)
                    begin
                        other_errors++;
                        $display("Unexpected write at %0t ns to address %h", $time, bus.address);
                    end
                    else
                    begin
                        check_value("write bus.address", write_addr_queue.pop_front(),
                                    bus.address);
                        check_value("write bus.data", 16'(write_data_queue.pop_front()),
                                    16'(bus.data));
                    end
                end
                enabled_cycles++;
            end
            prev_enable  = enable;
            prev_address = bus.address;
            prev_write   = bus.write_enable;
        end
    end

    initial
    begin
        logic [31:0] r;
        reset          = 1'b1;
        enable         = 1'b1;
        check_errors   = 0;
        other_errors   = 0;
        sync_count     = 0;
        cycles         = 0;
        enabled_cycles = 0;
        last_sync      = 0;
        owed_cycles    = 2;  // Vector fetch comes before the first sync
        prev_enable    = 1'b1;
        prev_address   = 16'h0000;
        prev_write     = 1'b0;
        seed           = 32'hb6ec6ad0;
        build_program();
        memory = ref_memory;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        while (sync_count < sync_target && cycles < cycle_limit)
        begin
            @(posedge clock);
            r = next_random();
            enable <= r[17:16] != 2'b00;  // Stall about one cycle in four
            cycles++;
        end
        if (sync_count < sync_target)
        begin
            other_errors++;
            $display("Timeout after %0d cycles with only %0d instructions started",
                     cycles, sync_count);
        end
        $display("Errors: %0d value mismatches, %0d other failures", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== cpu_core.f ====
+incdir+test
source/cpu_types_pkg.sv
source/opcode_pkg.sv
source/cpu_sequencer.sv
source/cpu_alu.sv
source/cpu_shift.sv
source/cpu_datapath.sv
source/cpu_address.sv
source/cpu_core.sv
test/cpu_core_tb.sv

// ==== Makefile ====
TOOL     := verilator
TOP      := cpu_core_tb
FILELIST := cpu_core.f
FLAGS    := --binary --timing --top-module $(TOP)
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench, fail unless it passes"
	@echo "make clean  remove build output and log"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
